// ==== all.f ====
hdl/afifo_pkg.sv
hdl/afifo_mem.sv
hdl/gray_sync.sv
hdl/afifo_wr_ctrl.sv
hdl/afifo_rd_ctrl.sv
hdl/async_fifo.sv
verif/async_fifo_tb.sv

// ==== hdl/afifo_mem.sv ====
// FIFO storage with no reset; contents are undefined until written
// write port on write_clk, read port is purely combinational

`timescale 1ns/1ps

module afifo_mem (
	input  logic               write_clk,
	input  afifo_pkg::wr_req_t wr_req,
	input  afifo_pkg::addr_t   rd_addr,
	output afifo_pkg::data_t   rd_data
);

	import afifo_pkg::*;

	data_t mem_q [FIFO_DEPTH];

	// write lands on the accepting edge
	always_ff @(posedge write_clk)
	begin
		if (wr_req.en)
			mem_q[wr_req.addr] <= wr_req.data;
	end

	// zero-latency read so the oldest word falls through to the output
	assign rd_data = mem_q[rd_addr];

endmodule

// ==== hdl/afifo_pkg.sv ====
// shared widths, types and helpers for the dual-clock FIFO
// FIFO_DEPTH must be a power of two and at least 4, because full inverts the
// top two bits of the Gray pointer

package afifo_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH  = 32;
	localparam int FIFO_DEPTH  = 8;
	localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH);
	// flops per clock-domain crossing
	localparam int SYNC_STAGES = 2;

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	// extra top bit flips on every wrap of the memory index
	typedef logic [ADDR_WIDTH:0]   ptr_t;

	// one domain's pointer, kept in both encodings
	typedef struct packed {
		ptr_t bin;
		ptr_t gray;
	} ptr_pair_t;

	// memory write request from the write controller
	typedef struct packed {
		logic  en;
		addr_t addr;
		data_t data;
	} wr_req_t;

	// binary to reflected Gray code
	function automatic ptr_t to_gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

endpackage

// ==== hdl/afifo_rd_ctrl.sv ====
// read side of the dual-clock FIFO, everything on read_clk
// first-word-fall-through: rd_addr always points at the oldest word, and
// empty may stay high a few cycles after a write lands

`timescale 1ns/1ps

module afifo_rd_ctrl (
	input  logic             read_clk,
	input  logic             reset_rsync,
	input  logic             read_en,
	// write pointer as seen from this domain
	input  afifo_pkg::ptr_t  wptr_gray_sync,
	output afifo_pkg::ptr_t  rptr_gray,
	output afifo_pkg::addr_t rd_addr,
	output logic             empty
);

	import afifo_pkg::*;

	ptr_pair_t rptr_q;
	ptr_pair_t rptr_next;
	logic      read_ok;

	////////////////////////////////////////////////////////////
	// pointer
	////////////////////////////////////////////////////////////

	assign read_ok = read_en && !empty;

	always_comb
	begin
		rptr_next.bin  = rptr_q.bin + ptr_t'(1);
		rptr_next.gray = to_gray(rptr_next.bin);
	end

	always_ff @(posedge read_clk)
	begin
		if (reset_rsync)
			rptr_q <= '0;
		else if (read_ok)
			rptr_q <= rptr_next;
	end

	assign rptr_gray = rptr_q.gray;

	////////////////////////////////////////////////////////////
	// empty flag and read address
	////////////////////////////////////////////////////////////

	// same lap and same index means nothing left to read
	assign empty   = (rptr_q.gray == wptr_gray_sync);
	assign rd_addr = rptr_q.bin[ADDR_WIDTH-1:0];

	// reads while empty must not consume anything
	a_hold_when_empty: assert property (@(posedge read_clk) disable iff (reset_rsync)
		empty |=> $stable(rptr_q.bin))
		else $error("afifo_rd_ctrl: read pointer moved while empty");

endmodule

// ==== hdl/afifo_wr_ctrl.sv ====
// write side of the dual-clock FIFO, everything on write_clk
// full is combinational from the registered write pointer and the
// synchronized read pointer, so it may stay high a few cycles too long

`timescale 1ns/1ps

module afifo_wr_ctrl (
	input  logic               write_clk,
	input  logic               reset_wsync,
	input  logic               write_en,
	input  afifo_pkg::data_t   write_data,
	// read pointer as seen from this domain
	input  afifo_pkg::ptr_t    rptr_gray_sync,
	output afifo_pkg::ptr_t    wptr_gray,
	output afifo_pkg::wr_req_t wr_req,
	output logic               full
);

	import afifo_pkg::*;

	ptr_pair_t wptr_q;
	ptr_pair_t wptr_next;
	ptr_t      full_match;
	logic      write_ok;

	////////////////////////////////////////////////////////////
	// pointer
	////////////////////////////////////////////////////////////

	assign write_ok = write_en && !full;

	always_comb
	begin
		wptr_next.bin  = wptr_q.bin + ptr_t'(1);
		wptr_next.gray = to_gray(wptr_next.bin);
	end

	always_ff @(posedge write_clk)
	begin
		if (reset_wsync)
			wptr_q <= '0;
		else if (write_ok)
			wptr_q <= wptr_next;
	end

	assign wptr_gray = wptr_q.gray;

	////////////////////////////////////////////////////////////
	// full flag and memory write
	////////////////////////////////////////////////////////////

	// one lap ahead of the reader: top two gray bits differ, the rest match
	assign full_match = {~rptr_gray_sync[ADDR_WIDTH:ADDR_WIDTH-1],
		rptr_gray_sync[ADDR_WIDTH-2:0]};
	assign full = (wptr_q.gray == full_match);

	assign wr_req = '{en: write_ok, addr: wptr_q.bin[ADDR_WIDTH-1:0], data: write_data};

	// a full FIFO holds its write pointer
	a_hold_when_full: assert property (@(posedge write_clk) disable iff (reset_wsync)
		full |=> $stable(wptr_q.bin))
		else $error("afifo_wr_ctrl: write pointer moved while full");

	a_not_full_after_reset: assert property (@(posedge write_clk)
		reset_wsync |=> !full)
		else $error("afifo_wr_ctrl: full set right after reset");

endmodule

// ==== hdl/async_fifo.sv ====
// dual-clock FIFO, 32-bit words from write_clk to read_clk
// each reset must already be synchronous to its own clock; read_data shows
// the oldest word whenever empty is low

`timescale 1ns/1ps

module async_fifo (
	// write domain
	input  logic             write_clk,
	input  logic             reset_wsync,
	input  logic             write_en,
	input  afifo_pkg::data_t write_data,
	output logic             full,
	// read domain
	input  logic             read_clk,
	input  logic             reset_rsync,
	input  logic             read_en,
	output afifo_pkg::data_t read_data,
	output logic             empty
);

	import afifo_pkg::*;

	wr_req_t wr_req;
	addr_t   rd_addr;
	ptr_t    wptr_gray;
	ptr_t    rptr_gray;
	ptr_t    wptr_gray_sync;
	ptr_t    rptr_gray_sync;

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	afifo_mem mem0 (
		.write_clk (write_clk),
		.wr_req    (wr_req),
		.rd_addr   (rd_addr),
		.rd_data   (read_data)
	);

	////////////////////////////////////////////////////////////
	// write domain
	////////////////////////////////////////////////////////////

	afifo_wr_ctrl wr_ctrl0 (
		.write_clk      (write_clk),
		.reset_wsync    (reset_wsync),
		.write_en       (write_en),
		.write_data     (write_data),
		.rptr_gray_sync (rptr_gray_sync),
		.wptr_gray      (wptr_gray),
		.wr_req         (wr_req),
		.full           (full)
	);

	// read pointer into the write domain
	gray_sync sync_r2w (
		.clk      (write_clk),
		.reset    (reset_wsync),
		.gray_in  (rptr_gray),
		.gray_out (rptr_gray_sync)
	);

	////////////////////////////////////////////////////////////
	// read domain
	////////////////////////////////////////////////////////////

	afifo_rd_ctrl rd_ctrl0 (
		.read_clk       (read_clk),
		.reset_rsync    (reset_rsync),
		.read_en        (read_en),
		.wptr_gray_sync (wptr_gray_sync),
		.rptr_gray      (rptr_gray),
		.rd_addr        (rd_addr),
		.empty          (empty)
	);

	// write pointer into the read domain
	gray_sync sync_w2r (
		.clk      (read_clk),
		.reset    (reset_rsync),
		.gray_in  (wptr_gray),
		.gray_out (wptr_gray_sync)
	);

endmodule

// ==== hdl/gray_sync.sv ====
// carries a Gray-coded pointer into the clock domain of clk
// the input must change by at most one bit at a time; a reset of the source
// domain while data is in flight breaks that rule and trips the check below

`timescale 1ns/1ps

module gray_sync (
	input  logic            clk,
	input  logic            reset,
	input  afifo_pkg::ptr_t gray_in,
	output afifo_pkg::ptr_t gray_out
);

	import afifo_pkg::*;

	ptr_t sync_q [SYNC_STAGES];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < SYNC_STAGES; i++)
				sync_q[i] <= '0;
		end
		else
		begin
			// first stage may go metastable, later stages settle it
			sync_q[0] <= gray_in;
			for (int i = 1; i < SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	assign gray_out = sync_q[SYNC_STAGES-1];

	// sampled on every change of the source pointer, whatever its clock
	a_one_bit_step: assert property (@(gray_in) disable iff (reset)
		$countones(gray_in ^ $past(gray_in)) <= 1)
		else $error("gray_sync: pointer changed by more than one bit");

endmodule

// ==== verif/async_fifo_golden.txt ====
# columns: word to write, word expected at the same place in the read stream
# T3 holds the word written while full, which must never be read back
T1
a1b2c3d4 a1b2c3d4
00000001 00000001
ffff0000 ffff0000
T2
3c5a0001 3c5a0001
3c5a0002 3c5a0002
3c5a0004 3c5a0004
3c5a0008 3c5a0008
c3a50010 c3a50010
c3a50020 c3a50020
c3a50040 c3a50040
c3a50080 c3a50080
T3
5e471ae1 5e471ae1
T4
71000001 71000001
72000002 72000002
73000003 73000003
74000004 74000004
75000005 75000005
76000006 76000006
77000007 77000007
78000008 78000008
79000009 79000009
T5
0badf00d 0badf00d
END

// ==== verif/async_fifo_tb.sv ====
// testbench for async_fifo with stimulus and expected words from the golden file
// run from the project root so that the golden file path resolves
// inputs change 2 ns after the rising edge of their own clock

`timescale 1ns/1ps

module async_fifo_tb;

	import afifo_pkg::*;

	localparam string       GOLDEN_PATH = "verif/async_fifo_golden.txt";
	localparam logic [31:0] SEED        = 32'hcd14_46f8;

	logic  write_clk;
	logic  reset_wsync;
	logic  write_en;
	data_t write_data;
	logic  full;
	logic  read_clk;
	logic  reset_rsync;
	logic  read_en;
	data_t read_data;
	logic  empty;

	// whole golden file with the test number of each data line
	data_t gold_wr[$];
	data_t gold_exp[$];
	int    gold_sec[$];
	// words of the test that runs now
	data_t sec_wr[$];
	data_t sec_exp[$];

	int          pass_count;
	int          fail_count;
	int          test_fails;
	int          cycle_count;
	int          cycle_limit;
	logic [31:0] wr_rng;
	logic [31:0] rd_rng;

	async_fifo dut0 (
		.write_clk   (write_clk),
		.reset_wsync (reset_wsync),
		.write_en    (write_en),
		.write_data  (write_data),
		.full        (full),
		.read_clk    (read_clk),
		.reset_rsync (reset_rsync),
		.read_en     (read_en),
		.read_data   (read_data),
		.empty       (empty)
	);

	// periods 40 and 56 ns so the two domains drift against each other
	always #20 write_clk = ~write_clk;
	always #28 read_clk = ~read_clk;

	always @(posedge write_clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout: run still busy after %0d write_clk cycles", cycle_count);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic load_golden(output bit ok);
		int    fd;
		int    n;
		int    sec;
		string line;
		data_t a;
		data_t b;
		ok = 0;
		sec = 0;
		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			n = $fgets(line, fd);
			if (n == 0)
				break;
			if (line.len() >= 3 && line.substr(0, 2) == "END")
			begin
				ok = (gold_wr.size() > 0);
				break;
			end
			if (line.getc(0) == "#")
				continue;
			if ($sscanf(line, "T%d", n) == 1)
				sec = n;
			else if ($sscanf(line, "%h %h", a, b) == 2)
			begin
				gold_wr.push_back(a);
				gold_exp.push_back(b);
				gold_sec.push_back(sec);
			end
		end
		$fclose(fd);
	endtask

	task automatic pick_section(input int s);
		sec_wr.delete();
		sec_exp.delete();
		foreach (gold_sec[i])
		begin
			if (gold_sec[i] == s)
			begin
				sec_wr.push_back(gold_wr[i]);
				sec_exp.push_back(gold_exp[i]);
			end
		end
	endtask

	task automatic check_value(input string name, input data_t got, input data_t exp);
		assert (got === exp)
			pass_count = pass_count + 1;
		else
		begin
			fail_count = fail_count + 1;
			$display("mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		assert (got === exp)
			pass_count = pass_count + 1;
		else
		begin
			fail_count = fail_count + 1;
			$display("mismatch at %0d ns: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic align_write();
		@(posedge write_clk);
		#2;
	endtask

	task automatic align_read();
		@(posedge read_clk);
		#2;
	endtask

	// holds the word until an edge sees full low
	task automatic write_word(input data_t d);
		bit taken;
		taken = 0;
		write_en = 1'b1;
		write_data = d;
		while (!taken)
		begin
			taken = !full;
			align_write();
		end
		write_en = 1'b0;
	endtask

	// waits for a word, takes it off read_data, then consumes it
	task automatic read_word(output data_t d);
		while (empty)
			align_read();
		d = read_data;
		read_en = 1'b1;
		align_read();
		read_en = 1'b0;
	endtask

	task automatic finish_test(input string name);
		if (fail_count == test_fails)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, fail_count - test_fails);
		test_fails = fail_count;
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic run_tests();
		data_t got;
		data_t sentinel;
		fork
			begin
				repeat (4) @(posedge write_clk);
				#2 reset_wsync = 1'b0;
			end
			begin
				repeat (4) @(posedge read_clk);
				#2 reset_rsync = 1'b0;
			end
		join
		check_flag("empty", empty, 1'b1);
		check_flag("full", full, 1'b0);
		finish_test("reset state");

		pick_section(1);
		align_write();
		foreach (sec_wr[i])
			write_word(sec_wr[i]);
		align_read();
		foreach (sec_exp[i])
		begin
			read_word(got);
			check_value("read_data", got, sec_exp[i]);
		end
		check_flag("empty", empty, 1'b1);
		finish_test("ordered transfer");

		pick_section(2);
		align_write();
		for (int i = 0; i < FIFO_DEPTH - 1; i++)
			write_word(sec_wr[i]);
		check_flag("full", full, 1'b0);
		write_word(sec_wr[FIFO_DEPTH-1]);
		check_flag("full", full, 1'b1);
		finish_test("fill and full");

		pick_section(3);
		sentinel = sec_wr[0];
		write_en = 1'b1;
		write_data = sentinel;
		repeat (2) align_write();
		write_en = 1'b0;
		check_flag("full", full, 1'b1);
		pick_section(2);
		align_read();
		for (int i = 0; i < FIFO_DEPTH; i++)
		begin
			read_word(got);
			check_value("read_data", got, sec_exp[i]);
			assert (got !== sentinel)
				pass_count = pass_count + 1;
			else
			begin
				fail_count = fail_count + 1;
				$display("at %0d ns the dropped word came out of the FIFO", $time);
			end
		end
		check_flag("empty", empty, 1'b1);
		repeat (2 * SYNC_STAGES + 2) align_read();
		check_flag("empty", empty, 1'b1);
		finish_test("dropped write");

		pick_section(4);
		fork
			begin
				align_write();
				foreach (sec_wr[i])
				begin
					while (wr_rng[1:0] == 2'b00)
					begin
						wr_rng = next_random(wr_rng);
						align_write();
					end
					wr_rng = next_random(wr_rng);
					write_word(sec_wr[i]);
				end
			end
			begin
				align_read();
				foreach (sec_exp[i])
				begin
					while (rd_rng[1:0] == 2'b00)
					begin
						rd_rng = next_random(rd_rng);
						align_read();
					end
					rd_rng = next_random(rd_rng);
					read_word(got);
					check_value("read_data", got, sec_exp[i]);
				end
			end
		join
		check_flag("empty", empty, 1'b1);
		finish_test("streaming");

		align_read();
		check_flag("empty", empty, 1'b1);
		read_en = 1'b1;
		repeat (3) align_read();
		read_en = 1'b0;
		check_flag("empty", empty, 1'b1);
		pick_section(5);
		align_write();
		write_word(sec_wr[0]);
		align_read();
		while (empty)
			align_read();
		check_value("read_data", read_data, sec_exp[0]);
		finish_test("read while empty");
	endtask

	initial
	begin
		bit loaded;
		write_clk = 1'b0;
		read_clk = 1'b0;
		reset_wsync = 1'b1;
		reset_rsync = 1'b1;
		write_en = 1'b0;
		read_en = 1'b0;
		write_data = '0;
		pass_count = 0;
		fail_count = 0;
		test_fails = 0;
		cycle_count = 0;
		cycle_limit = 0;
		wr_rng = SEED;
		rd_rng = next_random(SEED);
		load_golden(loaded);
		if (!loaded)
		begin
			fail_count = fail_count + 1;
			$display("could not read any test words from %s", GOLDEN_PATH);
		end
		else
		begin
			cycle_limit = 40 * gold_wr.size() + 200;
			run_tests();
		end
		$display("checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
